// File: Makefile
# Verilator build and run of the dense-layer accelerator testbench

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run tb_ita"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	verilator --binary -j 0 --timescale 1ns/1ps --top-module tb_ita \
		-f flist.f -Mdir obj_dir -o sim_tb_ita
	@out="$$(./obj_dir/sim_tb_ita)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "PASS: all tests"

clean:
	rm -rf obj_dir

// File: flist.f
+incdir+rtl
rtl/ita_data_pkg.sv
rtl/ita_ctrl_pkg.sv
rtl/ita_controller.sv
rtl/ita_dotp_acc.sv
rtl/ita_requant_act.sv
rtl/ita_output_fifo.sv
rtl/ita.sv
tests/tb_ita.sv

// File: rtl/ita.sv
// Dense-layer accelerator top with enable and tile delay lines, sequencer,
// dot product, requantizer and output FIFO
`default_nettype none

`include "ita_settings.svh"

module ita
  import ita_data_pkg::*;
  import ita_ctrl_pkg::*;
(
  input  logic         clk_i,
  input  logic         rst_ni,
  // Configuration held stable while busy
  input  tile_cnt_t    tiles_i,
  input  eps_mult_t    eps_mult_i,
  input  right_shift_t right_shift_i,
  input  add_t         add_i,
  input  activation_e  activation_i,
  // Handshakes
  input  logic         inp_valid_i,
  output logic         inp_ready_o,
  input  logic         inp_weight_valid_i,
  output logic         inp_weight_ready_o,
  input  logic         inp_bias_valid_i,
  output logic         inp_bias_ready_o,
  output logic         valid_o,
  input  logic         ready_i,
  output logic         busy_o,
  // Data
  input  inp_t         inp_i,
  input  weight_t      inp_weight_i,
  input  bias_t        inp_bias_i,
  output requant_oup_t oup_o
);

  logic calc_en, calc_en_q1, calc_en_q2, calc_en_q3, calc_en_q4;
  logic first_tile;
  logic last_tile, last_tile_q1, last_tile_q2, last_tile_q3, last_tile_q4;
  logic in_flight;
  logic fifo_empty;
  logic pop;

  activation_e  activation_q1, activation_q2, activation_q3;
  oup_t         result;
  requant_oup_t post_activation;

  always_ff @(posedge clk_i, negedge rst_ni) begin
    if (!rst_ni) begin
      calc_en_q1    <= 1'b0;
      calc_en_q2    <= 1'b0;
      calc_en_q3    <= 1'b0;
      calc_en_q4    <= 1'b0;
      last_tile_q1  <= 1'b0;
      last_tile_q2  <= 1'b0;
      last_tile_q3  <= 1'b0;
      last_tile_q4  <= 1'b0;
      activation_q1 <= IDENTITY;
      activation_q2 <= IDENTITY;
      activation_q3 <= IDENTITY;
    end else begin
      calc_en_q1    <= calc_en;
      calc_en_q2    <= calc_en_q1;
      calc_en_q3    <= calc_en_q2;
      calc_en_q4    <= calc_en_q3;
      last_tile_q1  <= last_tile;
      last_tile_q2  <= last_tile_q1;
      last_tile_q3  <= last_tile_q2;
      last_tile_q4  <= last_tile_q3;
      activation_q1 <= activation_i;
      activation_q2 <= activation_q1;
      activation_q3 <= activation_q2;
    end
  end

  assign in_flight = calc_en_q1 | calc_en_q2 | calc_en_q3 | calc_en_q4;

  ita_controller i_controller (
    .clk_i             (clk_i             ),
    .rst_ni            (rst_ni            ),
    .tiles_i           (tiles_i           ),
    .inp_valid_i       (inp_valid_i       ),
    .inp_weight_valid_i(inp_weight_valid_i),
    .inp_bias_valid_i  (inp_bias_valid_i  ),
    .inp_ready_o       (inp_ready_o       ),
    .inp_weight_ready_o(inp_weight_ready_o),
    .inp_bias_ready_o  (inp_bias_ready_o  ),
    .pop_i             (pop               ),
    .in_flight_i       (in_flight         ),
    .fifo_empty_i      (fifo_empty        ),
    .calc_en_o         (calc_en           ),
    .first_tile_o      (first_tile        ),
    .last_tile_o       (last_tile         ),
    .busy_o            (busy_o            )
  );

  // Enables go in undelayed since the operand stage is inside
  ita_dotp_acc i_dotp_acc (
    .clk_i       (clk_i       ),
    .rst_ni      (rst_ni      ),
    .calc_en_i   (calc_en     ),
    .first_tile_i(first_tile  ),
    .inp_i       (inp_i       ),
    .weight_i    (inp_weight_i),
    .bias_i      (inp_bias_i  ),
    .result_o    (result      )
  );

  ita_requant_act i_requant_act (
    .clk_i        (clk_i                     ),
    .rst_ni       (rst_ni                    ),
    .calc_en_i    (calc_en_q2 && last_tile_q2),
    .calc_en_q_i  (calc_en_q3 && last_tile_q3),
    .eps_mult_i   (eps_mult_i                ),
    .right_shift_i(right_shift_i             ),
    .add_i        (add_i                     ),
    .activation_i (activation_q3             ),
    .result_i     (result                    ),
    .data_o       (post_activation           )
  );

  ita_output_fifo i_output_fifo (
    .clk_i  (clk_i                     ),
    .rst_ni (rst_ni                    ),
    .push_i (calc_en_q4 && last_tile_q4),
    .data_i (post_activation           ),
    .ready_i(ready_i                   ),
    .valid_o(valid_o                   ),
    .data_o (oup_o                     ),
    .empty_o(fifo_empty                ),
    .pop_o  (pop                       )
  );

endmodule

`default_nettype wire

// File: rtl/ita_controller.sv
// Tile sequencer with input, weight and bias accept, tile position,
// output FIFO credits and busy flag
`default_nettype none

`include "ita_settings.svh"

module ita_controller
  import ita_ctrl_pkg::*;
(
  input  logic      clk_i,
  input  logic      rst_ni,
  input  tile_cnt_t tiles_i,
  input  logic      inp_valid_i,
  input  logic      inp_weight_valid_i,
  input  logic      inp_bias_valid_i,
  output logic      inp_ready_o,
  output logic      inp_weight_ready_o,
  output logic      inp_bias_ready_o,
  input  logic      pop_i,
  input  logic      in_flight_i,
  input  logic      fifo_empty_i,
  output logic      calc_en_o,
  output logic      first_tile_o,
  output logic      last_tile_o,
  output logic      busy_o
);

  localparam int unsigned credit_w = $clog2(`ITA_FIFO_DEPTH + 1);

  typedef logic [credit_w-1:0] credit_t;

  tile_cnt_t tile_q;
  credit_t   credit_q;
  logic      has_credit;
  logic      take_credit;

  assign first_tile_o = (tile_q == '0);
  assign last_tile_o  = (tile_q == tile_cnt_t'(tiles_i - 1'b1));
  assign has_credit   = (credit_q != '0);

  // A new output needs its bias and a free FIFO slot
  assign calc_en_o = inp_valid_i & inp_weight_valid_i &
                     (~first_tile_o | (inp_bias_valid_i & has_credit));

  assign inp_ready_o        = calc_en_o;
  assign inp_weight_ready_o = calc_en_o;
  assign inp_bias_ready_o   = calc_en_o & first_tile_o;
  assign take_credit        = calc_en_o & first_tile_o;

  always_ff @(posedge clk_i, negedge rst_ni) begin
    if (!rst_ni) begin
      tile_q <= '0;
    end else if (calc_en_o) begin
      tile_q <= last_tile_o ? '0 : tile_q + 1'b1;
    end
  end

  // Credits return when the output side pops a word
  always_ff @(posedge clk_i, negedge rst_ni) begin
    if (!rst_ni) begin
      credit_q <= credit_t'(`ITA_FIFO_DEPTH);
    end else begin
      credit_q <= credit_q + credit_t'(pop_i) - credit_t'(take_credit);
    end
  end

  // Busy while mid-output, in the pipeline or waiting in the FIFO
  assign busy_o = (tile_q != '0) | in_flight_i | ~fifo_empty_i;

endmodule

`default_nettype wire

// File: rtl/ita_ctrl_pkg.sv
// Control types for activation select and tile counting
`default_nettype none

`include "ita_settings.svh"

package ita_ctrl_pkg;

  typedef enum logic [0:0] {
    IDENTITY = 1'b0,
    RELU     = 1'b1
  } activation_e;

  // Tile position inside one output
  typedef logic [`ITA_TILE_W-1:0] tile_cnt_t;

endpackage

`default_nettype wire

// File: rtl/ita_data_pkg.sv
// Datapath word types for operands, bias, accumulators, requantized output
// and the requantization parameters
`default_nettype none

`include "ita_settings.svh"

package ita_data_pkg;

  typedef logic signed [`ITA_WI-1:0] data_t;
  typedef logic signed [23:0]        bias_elem_t;
  typedef logic signed [`ITA_WO-1:0] acc_t;

  typedef data_t      [`ITA_M-1:0] inp_t;
  // Row n of the tile feeds lane n
  typedef inp_t       [`ITA_N-1:0] weight_t;
  typedef bias_elem_t [`ITA_N-1:0] bias_t;
  typedef acc_t       [`ITA_N-1:0] oup_t;
  typedef data_t      [`ITA_N-1:0] requant_oup_t;

  typedef logic        [7:0] eps_mult_t;
  typedef logic        [4:0] right_shift_t;
  typedef logic signed [7:0] add_t;

endpackage

`default_nettype wire

// File: rtl/ita_dotp_acc.sv
// Operand register, N-lane dot product and per-lane accumulator
`default_nettype none

`include "ita_settings.svh"

module ita_dotp_acc
  import ita_data_pkg::*;
(
  input  logic    clk_i,
  input  logic    rst_ni,
  input  logic    calc_en_i,
  input  logic    first_tile_i,
  input  inp_t    inp_i,
  input  weight_t weight_i,
  input  bias_t   bias_i,
  output oup_t    result_o
);

  inp_t    inp_q;
  weight_t weight_q;
  bias_t   bias_q;
  logic    calc_en_q;
  logic    first_tile_q;
  oup_t    dotp;
  oup_t    acc_q;

  always_ff @(posedge clk_i, negedge rst_ni) begin
    if (!rst_ni) begin
      calc_en_q    <= 1'b0;
      first_tile_q <= 1'b0;
    end else begin
      calc_en_q    <= calc_en_i;
      first_tile_q <= first_tile_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (calc_en_i) begin
      inp_q    <= inp_i;
      weight_q <= weight_i;
      bias_q   <= bias_i;
    end
  end

  // Products sign-extended to accumulator width before the sum
  always_comb begin
    for (int n = 0; n < `ITA_N; n++) begin
      dotp[n] = '0;
      for (int m = 0; m < `ITA_M; m++) begin
        dotp[n] = dotp[n] + acc_t'(weight_q[n][m]) * acc_t'(inp_q[m]);
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (calc_en_q) begin
      for (int n = 0; n < `ITA_N; n++) begin
        acc_q[n] <= first_tile_q ? dotp[n] + acc_t'(bias_q[n]) : acc_q[n] + dotp[n];
      end
    end
  end

  assign result_o = acc_q;

endmodule

`default_nettype wire

// File: rtl/ita_output_fifo.sv
// Output FIFO (registered read side) and the valid/ready output port
`default_nettype none

`include "ita_settings.svh"

module ita_output_fifo
  import ita_data_pkg::*;
(
  input  logic         clk_i,
  input  logic         rst_ni,
  input  logic         push_i,
  input  requant_oup_t data_i,
  input  logic         ready_i,
  output logic         valid_o,
  output requant_oup_t data_o,
  output logic         empty_o,
  output logic         pop_o
);

  localparam int unsigned depth = `ITA_FIFO_DEPTH;
  localparam int unsigned ptr_w = (depth > 1) ? $clog2(depth) : 1;
  localparam int unsigned cnt_w = $clog2(depth + 1);

  typedef logic [ptr_w-1:0] ptr_t;
  typedef logic [cnt_w-1:0] cnt_t;

  requant_oup_t mem_q [depth];
  ptr_t         wr_ptr_q;
  ptr_t         rd_ptr_q;
  cnt_t         cnt_q;

  function automatic ptr_t next_ptr(input ptr_t ptr);
    return (ptr == ptr_t'(depth - 1)) ? '0 : ptr + 1'b1;
  endfunction

  assign empty_o = (cnt_q == '0);
  assign valid_o = ~empty_o;
  assign pop_o   = valid_o & ready_i;
  assign data_o  = empty_o ? '0 : mem_q[rd_ptr_q];

  always_ff @(posedge clk_i, negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      cnt_q    <= '0;
    end else begin
      if (push_i) begin
        wr_ptr_q <= next_ptr(wr_ptr_q);
      end
      if (pop_o) begin
        rd_ptr_q <= next_ptr(rd_ptr_q);
      end
      cnt_q <= cnt_q + cnt_t'(push_i) - cnt_t'(pop_o);
    end
  end

  // Controller credits keep a push from finding the FIFO full
  always_ff @(posedge clk_i) begin
    if (push_i) begin
      mem_q[wr_ptr_q] <= data_i;
    end
  end

endmodule

`default_nettype wire

// File: rtl/ita_requant_act.sv
// Requantizer with int8 saturation, then identity or ReLU activation
`default_nettype none

`include "ita_settings.svh"

module ita_requant_act
  import ita_data_pkg::*;
  import ita_ctrl_pkg::*;
(
  input  logic         clk_i,
  input  logic         rst_ni,
  input  logic         calc_en_i,
  input  logic         calc_en_q_i,
  input  eps_mult_t    eps_mult_i,
  input  right_shift_t right_shift_i,
  input  add_t         add_i,
  input  activation_e  activation_i,
  input  oup_t         result_i,
  output requant_oup_t data_o
);

  localparam int max_val = 2 ** (`ITA_WI - 1) - 1;
  localparam int min_val = -(2 ** (`ITA_WI - 1));

  typedef logic signed [`ITA_WO+9:0] wide_t;

  requant_oup_t requant_q;
  requant_oup_t act_q;

  function automatic data_t requant_lane(
    input acc_t         acc,
    input eps_mult_t    mult,
    input right_shift_t shift,
    input add_t         add
  );
    wide_t scaled;
    // Multiplier is unsigned, so widen it with a zero sign bit
    scaled = (wide_t'(acc) * wide_t'($signed({1'b0, mult}))) >>> shift;
    scaled = scaled + wide_t'(add);
    if (scaled > wide_t'(max_val)) begin
      return data_t'(max_val);
    end else if (scaled < wide_t'(min_val)) begin
      return data_t'(min_val);
    end
    return scaled[`ITA_WI-1:0];
  endfunction

  always_ff @(posedge clk_i, negedge rst_ni) begin
    if (!rst_ni) begin
      requant_q <= '0;
    end else if (calc_en_i) begin
      for (int n = 0; n < `ITA_N; n++) begin
        requant_q[n] <= requant_lane(result_i[n], eps_mult_i, right_shift_i, add_i);
      end
    end
  end

  always_ff @(posedge clk_i, negedge rst_ni) begin
    if (!rst_ni) begin
      act_q <= '0;
    end else if (calc_en_q_i) begin
      for (int n = 0; n < `ITA_N; n++) begin
        act_q[n] <= (activation_i == RELU && requant_q[n] < 0) ? '0 : requant_q[n];
      end
    end
  end

  assign data_o = act_q;

endmodule

`default_nettype wire

// File: rtl/ita_settings.svh
// Build-time sizes of the dense-layer datapath
`ifndef ITA_SETTINGS_SVH
`define ITA_SETTINGS_SVH

// Output lanes per vector
`define ITA_N 4

// Elements per input tile
`define ITA_M 4

`define ITA_WI 8

// Accumulator width per lane
`define ITA_WO 26

`define ITA_FIFO_DEPTH 4

// Holds a tile count of 1 to 15
`define ITA_TILE_W 4

`endif

// File: tests/tb_ita.sv
// Testbench for the dense-layer accelerator with random stimulus, a queue-based
// reference model, a back-pressure consumer and a watchdog
`default_nettype none

`include "ita_settings.svh"

module tb_ita
  import ita_data_pkg::*;
  import ita_ctrl_pkg::*;
();

  timeunit 1ns;
  timeprecision 1ps;

  localparam int n_single  = 24;
  localparam int n_multi   = 12;
  localparam int n_sat     = 16;
  localparam int n_bp      = 24;
  localparam int n_latency = 4;
  // Worst-case beat count with every multi-tile output at six tiles
  localparam int max_beats = n_single + n_multi * 6 + n_sat * 3 + n_bp * 2 + n_latency;
  localparam int credits   = `ITA_FIFO_DEPTH;

  logic         clk_i;
  logic         rst_ni;
  tile_cnt_t    tiles_i;
  eps_mult_t    eps_mult_i;
  right_shift_t right_shift_i;
  add_t         add_i;
  activation_e  activation_i;
  logic         inp_valid_i;
  logic         inp_ready_o;
  logic         inp_weight_valid_i;
  logic         inp_weight_ready_o;
  logic         inp_bias_valid_i;
  logic         inp_bias_ready_o;
  logic         valid_o;
  logic         ready_i;
  logic         busy_o;
  inp_t         inp_i;
  weight_t      inp_weight_i;
  bias_t        inp_bias_i;
  requant_oup_t oup_o;

  int           seed;
  int           ready_seed;
  requant_oup_t exp_q[$];
  int           started;
  int           pops;
  int           credit_stalls;
  int           saturated;
  int           relu_zeroed;
  bit           backpressure;
  string        cur_test;
  int           test_errors;
  int           total_errors;
  int           tests_run;
  int           tests_failed;

  ita i_dut (
    .clk_i             (clk_i             ),
    .rst_ni            (rst_ni            ),
    .tiles_i           (tiles_i           ),
    .eps_mult_i        (eps_mult_i        ),
    .right_shift_i     (right_shift_i     ),
    .add_i             (add_i             ),
    .activation_i      (activation_i      ),
    .inp_valid_i       (inp_valid_i       ),
    .inp_ready_o       (inp_ready_o       ),
    .inp_weight_valid_i(inp_weight_valid_i),
    .inp_weight_ready_o(inp_weight_ready_o),
    .inp_bias_valid_i  (inp_bias_valid_i  ),
    .inp_bias_ready_o  (inp_bias_ready_o  ),
    .valid_o           (valid_o           ),
    .ready_i           (ready_i           ),
    .busy_o            (busy_o            ),
    .inp_i             (inp_i             ),
    .inp_weight_i      (inp_weight_i      ),
    .inp_bias_i        (inp_bias_i        ),
    .oup_o             (oup_o             )
  );

  initial begin
    clk_i = 1'b0;
    forever #50 clk_i = ~clk_i;
  end

  task automatic report_mismatch(input string what, input logic [31:0] expected,
                                 input logic [31:0] actual);
    $display("[ERROR] %s %s: expected 0x%0h, actual 0x%0h", cur_test, what, expected, actual);
    test_errors++;
  endtask

  task automatic report_failure(input string msg);
    $display("[ERROR] %s: %s", cur_test, msg);
    test_errors++;
  endtask

  task automatic start_test(input string name);
    cur_test    = name;
    test_errors = 0;
  endtask

  task automatic finish_test(input int outputs);
    $display("test %s: %0d outputs, %0d errors", cur_test, outputs, test_errors);
    tests_run++;
    total_errors += test_errors;
    if (test_errors != 0) begin
      tests_failed++;
    end
  endtask

  // Requantize one lane with scale, shift, offset, int8 clamp and optional ReLU
  function automatic data_t expected_lane(input longint acc);
    longint scaled;
    scaled = (acc * longint'(eps_mult_i)) >>> right_shift_i;
    scaled = scaled + longint'(add_i);
    if (scaled > 127) begin
      scaled = 127;
      saturated++;
    end else if (scaled < -128) begin
      scaled = -128;
      saturated++;
    end
    if (activation_i == RELU && scaled < 0) begin
      scaled = 0;
      relu_zeroed++;
    end
    return data_t'(scaled);
  endfunction

  // Extreme operands push the sums past the int8 range
  function automatic data_t pick_operand(input bit big);
    if (big) begin
      return (($random(seed) & 1) != 0) ? data_t'(127) : data_t'(-128);
    end
    return data_t'($random(seed));
  endfunction

  task automatic set_config(input int tiles, input bit big, input bit relu);
    tiles_i       = tile_cnt_t'(tiles);
    eps_mult_i    = eps_mult_t'($random(seed));
    right_shift_i = big ? right_shift_t'($random(seed))
                        : right_shift_t'(14 + ($random(seed) & 3));
    add_i         = big ? add_t'($random(seed)) : add_t'($random(seed) % 16);
    activation_i  = relu ? RELU : IDENTITY;
  endtask

  // Ready is expected unless a new output finds no free FIFO credit
  task automatic check_ready(input bit first);
    bit exp_ready;
    exp_ready = !first || (started - pops < credits);
    if (first && !exp_ready) begin
      credit_stalls++;
    end
    if (inp_ready_o !== exp_ready) begin
      report_mismatch("inp_ready_o", 32'(exp_ready), 32'(inp_ready_o));
    end
    if (inp_weight_ready_o !== exp_ready) begin
      report_mismatch("inp_weight_ready_o", 32'(exp_ready), 32'(inp_weight_ready_o));
    end
    if (inp_bias_ready_o !== (exp_ready && first)) begin
      report_mismatch("inp_bias_ready_o", 32'(exp_ready && first), 32'(inp_bias_ready_o));
    end
  endtask

  // Runs from one falling edge to the one after the last accept
  task automatic send_output(input int tiles, input bit big);
    longint       acc [`ITA_N];
    inp_t         x;
    weight_t      w;
    bias_t        b;
    requant_oup_t word;
    bit           first;
    for (int t = 0; t < tiles; t++) begin
      first = (t == 0);
      for (int m = 0; m < `ITA_M; m++) begin
        x[m] = pick_operand(big);
      end
      for (int n = 0; n < `ITA_N; n++) begin
        for (int m = 0; m < `ITA_M; m++) begin
          w[n][m] = pick_operand(big);
        end
        // Later tiles carry junk bias that must be ignored
        b[n] = (big || !first) ? bias_elem_t'($random(seed))
                               : bias_elem_t'($random(seed) % 2048);
      end
      inp_i              = x;
      inp_weight_i       = w;
      inp_bias_i         = b;
      inp_valid_i        = 1'b1;
      inp_weight_valid_i = 1'b1;
      inp_bias_valid_i   = first;
      #1;
      while (!inp_ready_o) begin
        check_ready(first);
        @(negedge clk_i);
        #1;
      end
      check_ready(first);
      if (first) begin
        started++;
      end
      for (int n = 0; n < `ITA_N; n++) begin
        if (first) begin
          acc[n] = longint'(b[n]);
        end
        for (int m = 0; m < `ITA_M; m++) begin
          acc[n] += longint'(w[n][m]) * longint'(x[m]);
        end
      end
      @(negedge clk_i);
    end
    inp_valid_i        = 1'b0;
    inp_weight_valid_i = 1'b0;
    inp_bias_valid_i   = 1'b0;
    for (int n = 0; n < `ITA_N; n++) begin
      word[n] = expected_lane(acc[n]);
    end
    exp_q.push_back(word);
  endtask

  // Busy stays high until every expected word has left
  task automatic drain();
    do begin
      @(negedge clk_i);
      #3;
      if (exp_q.size() != 0 && busy_o !== 1'b1) begin
        report_mismatch("busy_o while outputs pending", 32'd1, 32'(busy_o));
      end
    end while (exp_q.size() != 0 || valid_o);
    if (busy_o !== 1'b0) begin
      report_mismatch("busy_o after drain", 32'd0, 32'(busy_o));
    end
    @(negedge clk_i);
  endtask

  // Consumer that applies random ready and compares every popped word
  initial begin : consumer
    requant_oup_t exp_word;
    logic         next_ready;
    next_ready = 1'b1;
    @(posedge rst_ni);
    forever begin
      @(negedge clk_i);
      ready_i = next_ready;
      #2;
      if (valid_o && ready_i) begin
        if (exp_q.size() == 0) begin
          report_failure("valid_o high while no output was expected");
        end else begin
          exp_word = exp_q.pop_front();
          if (oup_o !== exp_word) begin
            report_mismatch("oup_o", 32'(exp_word), 32'(oup_o));
          end
        end
        pops++;
      end else if (!valid_o && oup_o !== '0) begin
        report_mismatch("oup_o while empty", 32'd0, 32'(oup_o));
      end
      next_ready = backpressure ? (($random(ready_seed) & 3) == 0) : 1'b1;
    end
  end

  initial begin : watchdog
    repeat (16 + max_beats * 20) @(posedge clk_i);
    $display("watchdog: run did not finish within %0d cycles", 16 + max_beats * 20);
    $display("FAIL: see errors above");
    $finish;
  end

  initial begin : main
    int tiles;
    int latency;
    seed               = 32'hff70_0622;
    ready_seed         = seed ^ 32'h5a5a_5a5a;
    rst_ni             = 1'b0;
    tiles_i            = tile_cnt_t'(1);
    eps_mult_i         = '0;
    right_shift_i      = '0;
    add_i              = '0;
    activation_i       = IDENTITY;
    inp_valid_i        = 1'b0;
    inp_weight_valid_i = 1'b0;
    inp_bias_valid_i   = 1'b0;
    ready_i            = 1'b0;
    inp_i              = '0;
    inp_weight_i       = '0;
    inp_bias_i         = '0;
    repeat (16) @(negedge clk_i);
    rst_ni = 1'b1;

    start_test("reset");
    #1;
    if ({inp_ready_o, inp_weight_ready_o, inp_bias_ready_o} !== 3'b000) begin
      report_mismatch("ready outputs", 32'd0,
                      32'({inp_ready_o, inp_weight_ready_o, inp_bias_ready_o}));
    end
    if (valid_o !== 1'b0) begin
      report_mismatch("valid_o", 32'd0, 32'(valid_o));
    end
    if (busy_o !== 1'b0) begin
      report_mismatch("busy_o", 32'd0, 32'(busy_o));
    end
    if (oup_o !== '0) begin
      report_mismatch("oup_o", 32'd0, 32'(oup_o));
    end
    @(negedge clk_i);
    finish_test(0);

    start_test("single_tile");
    set_config(1, 1'b0, 1'b0);
    for (int i = 0; i < n_single; i++) begin
      send_output(1, 1'b0);
    end
    drain();
    finish_test(n_single);

    start_test("multi_tile");
    for (int i = 0; i < n_multi; i++) begin
      tiles = 2 + int'($unsigned($random(seed)) % 5);
      set_config(tiles, 1'b0, 1'b0);
      send_output(tiles, 1'b0);
      drain();
    end
    finish_test(n_multi);

    start_test("saturate_relu");
    saturated   = 0;
    relu_zeroed = 0;
    for (int i = 0; i < n_sat; i++) begin
      tiles = 1 + int'($unsigned($random(seed)) % 3);
      set_config(tiles, 1'b1, ($random(seed) & 1) != 0);
      send_output(tiles, 1'b1);
      drain();
    end
    if (saturated == 0) begin
      report_failure("no output word reached the int8 limits");
    end
    if (relu_zeroed == 0) begin
      report_failure("no negative lane was zeroed by ReLU");
    end
    finish_test(n_sat);

    start_test("backpressure");
    backpressure  = 1'b1;
    credit_stalls = 0;
    set_config(2, 1'b0, 1'b1);
    for (int i = 0; i < n_bp; i++) begin
      send_output(2, 1'b0);
    end
    drain();
    backpressure = 1'b0;
    if (credit_stalls == 0) begin
      report_failure("input side never stalled on FIFO credits");
    end
    finish_test(n_bp);

    start_test("latency");
    set_config(1, 1'b0, 1'b0);
    for (int i = 0; i < n_latency; i++) begin
      send_output(1, 1'b0);
      // Falling edges counted from the accept edge
      latency = 1;
      #1;
      while (!valid_o && latency < 10) begin
        @(negedge clk_i);
        #1;
        latency++;
      end
      if (latency != 5) begin
        report_mismatch("valid_o latency", 32'd5, 32'(latency));
      end
      drain();
    end
    finish_test(n_latency);

    $display("tests run %0d, tests failed %0d, errors %0d", tests_run, tests_failed,
             total_errors);
    if (total_errors == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

endmodule

`default_nettype wire
